/* hw/rv_core_pipe.sv */
`timescale 1ns/1ps

module rv_core_pipe (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [31:0]                   instr,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    output logic                          res_valid,
    output logic [rv_pkg::XLEN-1:0]       res_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] res_rd,
    output logic [rv_pkg::XLEN-1:0]       res_value,
    output logic                          res_we,
    output logic                          res_branch,
    output logic                          res_taken,
    output logic [rv_pkg::XLEN-1:0]       res_target,
    output logic                          res_illegal
);

    // Decode to operand
    logic                          dec_valid, dec_use_imm, dec_we, dec_illegal;
    logic [rv_pkg::XLEN-1:0]       dec_pc, dec_imm;
    logic [rv_pkg::REG_ADDR_W-1:0] dec_rs1, dec_rs2, dec_rd;
    rv_pkg::alu_op_e               dec_alu_op;

    // Register file read ports
    logic [rv_pkg::REG_ADDR_W-1:0] rs1, rs2;
    logic [rv_pkg::XLEN-1:0]       rs1_data, rs2_data;

    // Operand to execute
    logic                          op_valid, op_use_imm, op_we, op_illegal;
    logic [rv_pkg::XLEN-1:0]       op_pc, op_a, op_b, op_imm;
    logic [rv_pkg::REG_ADDR_W-1:0] op_rd;
    rv_pkg::alu_op_e               op_alu_op;

    // Write-back
    logic                          wb_en;
    logic [rv_pkg::REG_ADDR_W-1:0] wb_addr;
    logic [rv_pkg::XLEN-1:0]       wb_data;

    rv_decoder decoder_i (
        .clk, .rst, .instr_valid, .instr, .pc,
        .dec_valid, .dec_pc, .dec_rs1, .dec_rs2, .dec_rd, .dec_imm,
        .dec_alu_op, .dec_use_imm, .dec_we, .dec_illegal
    );

    rv_regfile regfile_i (
        .clk, .rst, .rs1, .rs2, .rs1_data, .rs2_data,
        .wb_en, .wb_addr, .wb_data
    );

    rv_operand_stage operand_i (
        .clk, .rst,
        .dec_valid, .dec_pc, .dec_rs1, .dec_rs2, .dec_rd, .dec_imm,
        .dec_alu_op, .dec_use_imm, .dec_we, .dec_illegal,
        .rs1_data, .rs2_data, .rs1, .rs2,
        .wb_en, .wb_addr, .wb_data,
        .op_valid, .op_pc, .op_a, .op_b, .op_imm, .op_rd,
        .op_alu_op, .op_use_imm, .op_we, .op_illegal
    );

    rv_execute execute_i (
        .clk, .rst,
        .op_valid, .op_pc, .op_a, .op_b, .op_imm, .op_rd,
        .op_alu_op, .op_use_imm, .op_we, .op_illegal,
        .wb_en, .wb_addr, .wb_data,
        .res_valid, .res_pc, .res_rd, .res_value, .res_we,
        .res_branch, .res_taken, .res_target, .res_illegal
    );

endmodule

/* hw/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [31:0]                   instr,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    output logic                          dec_valid,
    output logic [rv_pkg::XLEN-1:0]       dec_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] dec_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] dec_rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0] dec_rd,
    output logic [rv_pkg::XLEN-1:0]       dec_imm,
    output rv_pkg::alu_op_e               dec_alu_op,
    output logic                          dec_use_imm,
    output logic                          dec_we,
    output logic                          dec_illegal
);

    // Base mapping of funct3 shared by OP and OP-IMM
    function automatic rv_pkg::alu_op_e f3_to_op(input logic [2:0] f3);
        case (f3)
            3'b000:  return rv_pkg::ADD;
            3'b001:  return rv_pkg::SLL;
            3'b010:  return rv_pkg::SLT;
            3'b011:  return rv_pkg::SLTU;
            3'b100:  return rv_pkg::XOR;
            3'b101:  return rv_pkg::SRL;
            3'b110:  return rv_pkg::OR;
            default: return rv_pkg::AND;
        endcase
    endfunction

    rv_pkg::opcode_e               opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1_n, rs2_n, rd_n;
    logic [rv_pkg::XLEN-1:0]       imm_n;
    rv_pkg::alu_op_e               alu_n;
    logic                          use_imm_n, we_n, illegal_n;

    // ------------------------------
    // Field extraction
    // ------------------------------
    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Standard RV32I immediate formats, all sign-extended
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        rs1_n     = '0;
        rs2_n     = '0;
        rd_n      = '0;
        imm_n     = '0;
        alu_n     = rv_pkg::NOP;
        use_imm_n = 1'b0;
        we_n      = 1'b0;
        illegal_n = 1'b0;

        case (opcode)
            rv_pkg::LUI: begin
                rd_n      = instr[11:7];
                imm_n     = imm_u;
                alu_n     = rv_pkg::PASS_B;
                use_imm_n = 1'b1;
                we_n      = 1'b1;
            end
            rv_pkg::AUIPC: begin
                rd_n      = instr[11:7];
                imm_n     = imm_u;
                alu_n     = rv_pkg::PC_ADD;
                use_imm_n = 1'b1;
                we_n      = 1'b1;
            end
            // use_imm tells execute the jump base is rs1, not the pc
            rv_pkg::JAL: begin
                rd_n  = instr[11:7];
                imm_n = imm_j;
                alu_n = rv_pkg::LINK;
                we_n  = 1'b1;
            end
            rv_pkg::JALR: begin
                rs1_n     = instr[19:15];
                rd_n      = instr[11:7];
                imm_n     = imm_i;
                alu_n     = rv_pkg::LINK;
                use_imm_n = 1'b1;
                we_n      = 1'b1;
            end
            rv_pkg::BRANCH: begin
                rs1_n = instr[19:15];
                rs2_n = instr[24:20];
                imm_n = imm_b;
                case (funct3)
                    3'b000:  alu_n = rv_pkg::BEQ;
                    3'b001:  alu_n = rv_pkg::BNE;
                    3'b100:  alu_n = rv_pkg::BLT;
                    3'b101:  alu_n = rv_pkg::BGE;
                    3'b110:  alu_n = rv_pkg::BLTU;
                    3'b111:  alu_n = rv_pkg::BGEU;
                    default: illegal_n = 1'b1;
                endcase
            end
            rv_pkg::OP_IMM: begin
                rs1_n     = instr[19:15];
                rd_n      = instr[11:7];
                imm_n     = imm_i;
                alu_n     = f3_to_op(funct3);
                use_imm_n = 1'b1;
                we_n      = 1'b1;
                // Shift amounts sit in imm[4:0], funct7 must be a legal pattern
                if (funct3 == 3'b001 && funct7 != rv_pkg::F7_BASE) begin
                    illegal_n = 1'b1;
                end
                if (funct3 == 3'b101) begin
                    if (funct7 == rv_pkg::F7_ALT) begin
                        alu_n = rv_pkg::SRA;
                    end else if (funct7 != rv_pkg::F7_BASE) begin
                        illegal_n = 1'b1;
                    end
                end
            end
            rv_pkg::OP: begin
                rs1_n = instr[19:15];
                rs2_n = instr[24:20];
                rd_n  = instr[11:7];
                alu_n = f3_to_op(funct3);
                we_n  = 1'b1;
                if (funct7 == rv_pkg::F7_ALT && funct3 == 3'b000) begin
                    alu_n = rv_pkg::SUB;
                end else if (funct7 == rv_pkg::F7_ALT && funct3 == 3'b101) begin
                    alu_n = rv_pkg::SRA;
                end else if (funct7 != rv_pkg::F7_BASE) begin
                    illegal_n = 1'b1;
                end
            end
            // No data memory behind this pipe
            rv_pkg::LOAD: begin
                imm_n     = imm_i;
                illegal_n = 1'b1;
            end
            rv_pkg::STORE: begin
                imm_n     = imm_s;
                illegal_n = 1'b1;
            end
            // FENCE, SYSTEM and anything unknown
            default: illegal_n = 1'b1;
        endcase

        // Illegal instructions read and write nothing
        if (illegal_n) begin
            rs1_n     = '0;
            rs2_n     = '0;
            rd_n      = '0;
            alu_n     = rv_pkg::NOP;
            use_imm_n = 1'b0;
            we_n      = 1'b0;
        end
    end

    // ------------------------------
    // Decode register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    // Payload only loads with a strobe
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_pc      <= pc;
            dec_rs1     <= rs1_n;
            dec_rs2     <= rs2_n;
            dec_rd      <= rd_n;
            dec_imm     <= imm_n;
            dec_alu_op  <= alu_n;
            dec_use_imm <= use_imm_n;
            dec_we      <= we_n;
            dec_illegal <= illegal_n;
        end
    end

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          op_valid,
    input  logic [rv_pkg::XLEN-1:0]       op_pc,
    input  logic [rv_pkg::XLEN-1:0]       op_a,
    input  logic [rv_pkg::XLEN-1:0]       op_b,
    input  logic [rv_pkg::XLEN-1:0]       op_imm,
    input  logic [rv_pkg::REG_ADDR_W-1:0] op_rd,
    input  rv_pkg::alu_op_e               op_alu_op,
    input  logic                          op_use_imm,
    input  logic                          op_we,
    input  logic                          op_illegal,
    output logic                          wb_en,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic                          res_valid,
    output logic [rv_pkg::XLEN-1:0]       res_pc,
    output logic [rv_pkg::REG_ADDR_W-1:0] res_rd,
    output logic [rv_pkg::XLEN-1:0]       res_value,
    output logic                          res_we,
    output logic                          res_branch,
    output logic                          res_taken,
    output logic [rv_pkg::XLEN-1:0]       res_target,
    output logic                          res_illegal
);

    logic [rv_pkg::XLEN-1:0] b_opnd, result, target_base, target_sum, target;
    logic [4:0]              shamt;
    logic                    eq, lt_s, lt_u, taken, is_branch, is_link;

    // ------------------------------
    // Operands and compares
    // ------------------------------
    assign b_opnd = op_use_imm ? op_imm : op_b;
    assign shamt  = b_opnd[4:0];

    // Shared by SLT/SLTU and the branch conditions
    assign eq   = (op_a == b_opnd);
    assign lt_s = ($signed(op_a) < $signed(b_opnd));
    assign lt_u = (op_a < b_opnd);

    assign is_branch = op_alu_op inside {rv_pkg::BEQ, rv_pkg::BNE, rv_pkg::BLT,
                                         rv_pkg::BGE, rv_pkg::BLTU, rv_pkg::BGEU};
    assign is_link   = (op_alu_op == rv_pkg::LINK);

    // One adder for branch, JAL, JALR and AUIPC, JALR is the only rs1 base
    assign target_base = (is_link && op_use_imm) ? op_a : op_pc;
    assign target_sum  = target_base + op_imm;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (op_alu_op)
            rv_pkg::ADD:    result = op_a + b_opnd;
            rv_pkg::SUB:    result = op_a - b_opnd;
            rv_pkg::SLL:    result = op_a << shamt;
            rv_pkg::SLT:    result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
            rv_pkg::SLTU:   result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
            rv_pkg::XOR:    result = op_a ^ b_opnd;
            rv_pkg::SRL:    result = op_a >> shamt;
            rv_pkg::SRA:    result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::OR:     result = op_a | b_opnd;
            rv_pkg::AND:    result = op_a & b_opnd;
            rv_pkg::PASS_B: result = b_opnd;
            rv_pkg::PC_ADD: result = target_sum;
            // Link value is the return address
            rv_pkg::LINK:   result = op_pc + 32'd4;
            rv_pkg::BEQ:    taken  = eq;
            rv_pkg::BNE:    taken  = !eq;
            rv_pkg::BLT:    taken  = lt_s;
            rv_pkg::BGE:    taken  = !lt_s;
            rv_pkg::BLTU:   taken  = lt_u;
            rv_pkg::BGEU:   taken  = !lt_u;
            default:        result = '0;
        endcase
    end

    // JALR clears bit 0, zero for anything that does not jump
    always_comb begin
        if (is_branch) begin
            target = target_sum;
        end else if (is_link) begin
            target = {target_sum[rv_pkg::XLEN-1:1], target_sum[0] & !op_use_imm};
        end else begin
            target = '0;
        end
    end

    // ------------------------------
    // Write-back, seen by regfile and bypass
    // ------------------------------
    assign wb_en   = op_valid && !op_illegal && op_we && (op_rd != '0);
    assign wb_addr = op_rd;
    assign wb_data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= op_valid;
        end
    end

    // Retired record, decoder already zeroed illegal control
    always_ff @(posedge clk) begin
        if (op_valid) begin
            res_pc      <= op_pc;
            res_rd      <= op_rd;
            res_value   <= wb_en ? wb_data : '0;
            res_we      <= wb_en;
            res_branch  <= is_branch;
            res_taken   <= taken;
            res_target  <= target;
            res_illegal <= op_illegal;
        end
    end

endmodule

/* hw/rv_operand_stage.sv */
`timescale 1ns/1ps

module rv_operand_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dec_valid,
    input  logic [rv_pkg::XLEN-1:0]       dec_pc,
    input  logic [rv_pkg::REG_ADDR_W-1:0] dec_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] dec_rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] dec_rd,
    input  logic [rv_pkg::XLEN-1:0]       dec_imm,
    input  rv_pkg::alu_op_e               dec_alu_op,
    input  logic                          dec_use_imm,
    input  logic                          dec_we,
    input  logic                          dec_illegal,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    input  logic                          wb_en,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic                          op_valid,
    output logic [rv_pkg::XLEN-1:0]       op_pc,
    output logic [rv_pkg::XLEN-1:0]       op_a,
    output logic [rv_pkg::XLEN-1:0]       op_b,
    output logic [rv_pkg::XLEN-1:0]       op_imm,
    output logic [rv_pkg::REG_ADDR_W-1:0] op_rd,
    output rv_pkg::alu_op_e               op_alu_op,
    output logic                          op_use_imm,
    output logic                          op_we,
    output logic                          op_illegal
);

    logic [rv_pkg::XLEN-1:0] a_n, b_n;

    // Register file ports are addressed straight from decode
    assign rs1 = dec_rs1;
    assign rs2 = dec_rs2;

    // The instruction in execute writes on the same edge we latch,
    // so its result bypasses the register file
    // wb_en already excludes x0
    assign a_n = (wb_en && wb_addr == dec_rs1) ? wb_data : rs1_data;
    assign b_n = (wb_en && wb_addr == dec_rs2) ? wb_data : rs2_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            op_pc      <= dec_pc;
            op_a       <= a_n;
            op_b       <= b_n;
            op_imm     <= dec_imm;
            op_rd      <= dec_rd;
            op_alu_op  <= dec_alu_op;
            op_use_imm <= dec_use_imm;
            op_we      <= dec_we;
            op_illegal <= dec_illegal;
        end
    end

endmodule

/* hw/rv_pkg.sv */
package rv_pkg;

    // ------------------------------
    // Data path widths
    // ------------------------------

    // RV32I data width
    localparam int XLEN = 32;

    // Register pointer width, 32 architectural registers
    localparam int REG_ADDR_W = 5;

    // Width of the execute operation code
    localparam int ALU_OP_W = 5;

    // ------------------------------
    // Instruction field constants
    // ------------------------------

    // funct7 for the base encodings of OP and the shifts
    localparam logic [6:0] F7_BASE = 7'b0000000;

    // funct7 selecting SUB and SRA
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        MISC_MEM = 7'b0001111,
        SYSTEM   = 7'b1110011
    } opcode_e;

    // Operations carried from decode to execute
    typedef enum logic [ALU_OP_W-1:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B,
        PC_ADD,
        LINK,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        NOP
    } alu_op_e;

endpackage

/* hw/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data,
    input  logic                          wb_en,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [rv_pkg::XLEN-1:0]       wb_data
);

    localparam int NUM_REGS = 2 ** rv_pkg::REG_ADDR_W;

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:NUM_REGS-1];

    // Architectural state is cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Combinational read, x0 reads zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* project.f */
+incdir+include
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_operand_stage.sv
hw/rv_execute.sv
hw/rv_core_pipe.sv
verif/tb_rv_core_pipe.sv

/* include/tb_rv_model.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// ------------------------------
// Expected retirement record
// ------------------------------
typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        we;
    logic        branch;
    logic        taken;
    logic [31:0] target;
    logic        illegal;
    // Clock edge on which res_valid must rise
    logic [31:0] due;
} expect_t;

// Reference integer ALU
// alt selects SUB or SRA
function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] x, input logic [31:0] y);
    case (f3)
        3'd0:    return alt ? x - y : x + y;
        3'd1:    return x << y[4:0];
        3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'd3:    return (x < y) ? 32'd1 : 32'd0;
        3'd4:    return x ^ y;
        3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6:    return x | y;
        default: return x & y;
    endcase
endfunction

// ------------------------------
// Instruction-level execution
// ------------------------------
// a and b are the architectural values of the rs1 and rs2 fields
function automatic expect_t reference_execute(input logic [31:0] ins, input logic [31:0] pc,
                                              input logic [31:0] a, input logic [31:0] b);
    expect_t     e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] res;
    logic        legal;
    logic        writes;
    logic        alt;
    e      = '0;
    e.pc   = pc;
    f3     = ins[14:12];
    f7     = ins[31:25];
    imm_i  = {{20{ins[31]}}, ins[31:20]};
    imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u  = {ins[31:12], 12'b0};
    imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    res    = '0;
    legal  = 1'b1;
    writes = 1'b0;
    alt    = (f7 == rv_pkg::F7_ALT);
    case (ins[6:0])
        rv_pkg::LUI: begin
            res    = imm_u;
            writes = 1'b1;
        end
        rv_pkg::AUIPC: begin
            res    = pc + imm_u;
            writes = 1'b1;
        end
        rv_pkg::JAL: begin
            res      = pc + 32'd4;
            e.target = pc + imm_j;
            writes   = 1'b1;
        end
        rv_pkg::JALR: begin
            res      = pc + 32'd4;
            e.target = (a + imm_i) & ~32'd1;
            writes   = 1'b1;
        end
        rv_pkg::BRANCH: begin
            e.branch = 1'b1;
            e.target = pc + imm_b;
            case (f3)
                3'd0:    e.taken = (a == b);
                3'd1:    e.taken = (a != b);
                3'd4:    e.taken = ($signed(a) < $signed(b));
                3'd5:    e.taken = ($signed(a) >= $signed(b));
                3'd6:    e.taken = (a < b);
                3'd7:    e.taken = (a >= b);
                default: legal = 1'b0;
            endcase
        end
        rv_pkg::OP_IMM: begin
            writes = 1'b1;
            // Shifts keep funct7 in the upper immediate bits
            if (f3 == 3'd1) begin
                legal = (f7 == rv_pkg::F7_BASE);
            end else if (f3 == 3'd5) begin
                legal = (f7 == rv_pkg::F7_BASE) || alt;
            end
            res = alu_calc(f3, alt && f3 == 3'd5, a, imm_i);
        end
        rv_pkg::OP: begin
            writes = 1'b1;
            legal  = (f7 == rv_pkg::F7_BASE) || (alt && (f3 == 3'd0 || f3 == 3'd5));
            res    = alu_calc(f3, alt, a, b);
        end
        // Loads, stores, FENCE, SYSTEM and unknown opcodes
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        e.branch  = 1'b0;
        e.taken   = 1'b0;
        e.target  = '0;
        e.illegal = 1'b1;
        writes    = 1'b0;
    end
    e.rd    = writes ? ins[11:7] : 5'd0;
    e.we    = writes && (e.rd != 5'd0);
    e.value = e.we ? res : '0;
    return e;
endfunction

// ------------------------------
// Random instruction encoder
// ------------------------------
// Registers come from x0..x7 so dependencies are frequent
function automatic logic [31:0] random_instr(input logic [31:0] r0, input logic [31:0] r1);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [2:0]  bf3;
    logic [6:0]  f7;
    logic [11:0] imm;
    rd  = {2'b00, r0[6:4]};
    rs1 = {2'b00, r0[9:7]};
    rs2 = {2'b00, r0[12:10]};
    f3  = r1[2:0];
    f7  = (r1[3] && (f3 == 3'd0 || f3 == 3'd5)) ? rv_pkg::F7_ALT : rv_pkg::F7_BASE;
    imm = r1[31:20];
    if (f3 == 3'd1) begin
        imm[11:5] = rv_pkg::F7_BASE;
    end else if (f3 == 3'd5) begin
        imm[11:5] = r1[3] ? rv_pkg::F7_ALT : rv_pkg::F7_BASE;
    end
    // 010 and 011 are not branches, fold them onto BLTU and BGEU
    bf3 = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
    case (r0[3:0])
        4'd0, 4'd1, 4'd2, 4'd3: return {f7, rs2, rs1, f3, rd, rv_pkg::OP};
        4'd4, 4'd5, 4'd6:       return {imm, rs1, f3, rd, rv_pkg::OP_IMM};
        4'd7:                   return {r1[31:12], rd, rv_pkg::LUI};
        4'd8:                   return {r1[31:12], rd, rv_pkg::AUIPC};
        4'd9:                   return {r1[31:12], rd, rv_pkg::JAL};
        4'd10:                  return {r1[31:20], rs1, 3'b000, rd, rv_pkg::JALR};
        4'd11, 4'd12: begin
            return {r1[31:25], rs2, rs1, bf3, r1[11:7], rv_pkg::BRANCH};
        end
        4'd13: begin
            case (r1[6:4])
                3'd0:    return {r1[31:7], rv_pkg::LOAD};
                3'd1:    return {r1[31:7], rv_pkg::STORE};
                3'd2:    return {r1[31:7], rv_pkg::MISC_MEM};
                3'd3:    return {r1[31:7], rv_pkg::SYSTEM};
                3'd4:    return {7'b0000001, rs2, rs1, f3, rd, rv_pkg::OP};
                3'd5:    return {rv_pkg::F7_ALT, r1[24:20], rs1, 3'b001, rd, rv_pkg::OP_IMM};
                3'd6:    return {r1[31:15], 2'b01, r1[7], r1[11:7], rv_pkg::BRANCH};
                default: return {r1[31:7], 7'b1011011};
            endcase
        end
        4'd14:   return {f7, rs2, rs1, f3, rd, rv_pkg::OP};
        default: return {imm, rs1, f3, rd, rv_pkg::OP_IMM};
    endcase
endfunction

`endif

/* verif/tb_rv_core_pipe.sv */
`timescale 1ns/1ps

module tb_rv_core_pipe;

    localparam int NUM_INSTR     = 2000;
    localparam int DRAIN_TIMEOUT = 200;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        res_valid;
    logic [31:0] res_pc;
    logic [4:0]  res_rd;
    logic [31:0] res_value;
    logic        res_we;
    logic        res_branch;
    logic        res_taken;
    logic [31:0] res_target;
    logic        res_illegal;

    integer      seed;
    logic [31:0] cycle;
    logic [31:0] model_regs [0:31];

    `include "tb_rv_model.svh"

    // Expected results in strobe order
    expect_t exp_q[$];

    rv_core_pipe dut_i (
        .clk, .rst, .instr_valid, .instr, .pc,
        .res_valid, .res_pc, .res_rd, .res_value, .res_we,
        .res_branch, .res_taken, .res_target, .res_illegal
    );

    // ------------------------------
    // Clock and edge counter
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Result mismatch");
        end
    endtask

    // ------------------------------
    // Monitor
    // ------------------------------
    // Sample mid-cycle where the outputs are stable
    initial begin : monitor
        expect_t e;
        forever begin
            @(negedge clk);
            if (res_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("A result retired at %0t ns with no instruction in flight", $time);
                    $display("TEST FAILED");
                    $fatal(1, "Unexpected result");
                end else begin
                    e = exp_q.pop_front();
                    check_value("retire edge", cycle, e.due);
                    check_value("res_pc", res_pc, e.pc);
                    check_value("res_rd", {27'b0, res_rd}, {27'b0, e.rd});
                    check_value("res_value", res_value, e.value);
                    check_value("res_we", {31'b0, res_we}, {31'b0, e.we});
                    check_value("res_branch", {31'b0, res_branch}, {31'b0, e.branch});
                    check_value("res_taken", {31'b0, res_taken}, {31'b0, e.taken});
                    check_value("res_target", res_target, e.target);
                    check_value("res_illegal", {31'b0, res_illegal}, {31'b0, e.illegal});
                end
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin : stimulus
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] word;
        logic [31:0] pc_val;
        expect_t     e;
        int          gap;
        int          wait_cycles;
        seed        = 32'hebee2280;
        cycle       = '0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < NUM_INSTR; n++) begin
            r0     = $random(seed);
            r1     = $random(seed);
            pc_val = $random(seed) & ~32'd3;
            word   = random_instr(r0, r1);
            // Sequential ISA execution on the model's own registers
            e = reference_execute(word, pc_val, model_regs[word[19:15]],
                                  model_regs[word[24:20]]);
            if (e.we) begin
                model_regs[e.rd] = e.value;
            end
            // Strobe is taken on edge cycle+1 and retires on edge cycle+3
            e.due = cycle + 3;
            exp_q.push_back(e);
            instr_valid = 1'b1;
            instr       = word;
            pc          = pc_val;
            @(negedge clk);
            instr_valid = 1'b0;
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
        end

        // Let the pipe drain
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out with %0d results still missing from the pipeline",
                     exp_q.size());
            $display("TEST FAILED");
            $fatal(1, "Drain timeout");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
